/* design/lsu_pkg.sv */
// shared types of the load-store unit, fixed 32-bit data path
// the bus address in data_bus_t is always word aligned
// size code 2'b11 is treated as a byte access everywhere
package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  // byte offset within a word
  localparam int unsigned BYTE_OFFSET_W = 2;
  // data word
  localparam int unsigned DATA_W = 32;

  ////////////////////
  // types
  ////////////////////

  // access size, 2'b11 also decodes as byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // one command from the execute stage
  typedef struct packed {
    logic              we;
    lsu_type_e         size;
    logic              sign_ext;
    logic [DATA_W-1:0] wdata;
  } lsu_cmd_t;

  // address phase of a bus request
  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic              we;
    logic [3:0]        be;
    logic [DATA_W-1:0] wdata;
  } data_bus_t;

  // attributes captured at each grant, used when the response returns
  typedef struct packed {
    logic [BYTE_OFFSET_W-1:0] offset;
    lsu_type_e                size;
    logic                     sign_ext;
    logic                     we;
  } xfer_ctrl_t;

endpackage

/* design/lsu_store_align.sv */
// byte enables and store data lanes for one bus beat, purely combinational
// handle_mis_i selects the second part of a split access
module lsu_store_align
  import lsu_pkg::*;
(
  input  logic [BYTE_OFFSET_W-1:0] offset_i,
  input  lsu_type_e                size_i,
  input  logic                     handle_mis_i,
  input  logic [DATA_W-1:0]        wdata_i,
  output logic [3:0]               be_o,
  output logic [DATA_W-1:0]        wdata_o
);

  // lanes covered by the access before shifting
  logic [3:0]          size_mask;
  // enables over two words, upper half spills into the next word
  logic [7:0]          be_span;
  // store data doubled so a shift gives a rotation
  logic [2*DATA_W-1:0] wdata_dbl;

  ////////////////////
  // byte enables
  ////////////////////

  always_comb begin
    unique case (size_i)
      LSU_WORD: size_mask = 4'b1111;
      LSU_HALF: size_mask = 4'b0011;
      // byte, and the 2'b11 alias
      default:  size_mask = 4'b0001;
    endcase
  end

  assign be_span = {4'b0000, size_mask} << offset_i;

  // first part keeps lanes up to 3
  // second part takes the bytes that ran past lane 3, moved down to lane 0
  assign be_o = handle_mis_i ? be_span[7:4] : be_span[3:0];

  ////////////////////
  // data rotation
  ////////////////////

  // rotate left by offset bytes, each byte then sits on its own lane
  // in both parts of a split access
  assign wdata_dbl = {wdata_i, wdata_i} << {offset_i, 3'b000};
  assign wdata_o   = wdata_dbl[2*DATA_W-1:DATA_W];

  // a byte access never ends up with an empty enable set
  a_byte_be_nonzero: assert final (
    $isunknown({size_i, offset_i, handle_mis_i}) ||
    !(size_i inside {LSU_BYTE, 2'b11}) ||
    (be_o != 4'b0000)
  );

endmodule

/* design/lsu_load_align.sv */
// load realignment and extension for split and unsplit accesses
// the result is only meaningful in the cycle of the final rvalid
// the first beat is kept from rdata_update until the second beat arrives
module lsu_load_align
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              ctrl_update_i,
  input  logic              rdata_update_i,
  input  xfer_ctrl_t        xfer_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  output xfer_ctrl_t        xfer_q_o,
  output logic [DATA_W-1:0] rdata_o
);

  xfer_ctrl_t        xfer_q;
  // upper three bytes of the first beat, lane 0 is never needed
  logic [DATA_W-1:8] rdata_q;
  // current beat moved down to the addressed byte
  logic [DATA_W-1:0] beat_shift;
  logic [DATA_W-1:0] word_rebuilt;
  logic [15:0]       half_raw;
  logic [7:0]        byte_raw;

  ////////////////////
  // registers
  ////////////////////

  // transfer attributes, refreshed at each grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer_q <= '0;
    end else if (ctrl_update_i) begin
      xfer_q <= xfer_i;
    end
  end

  // first beat of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[DATA_W-1:8];
    end
  end

  assign xfer_q_o = xfer_q;

  ////////////////////
  // realignment
  ////////////////////

  assign beat_shift = data_rdata_i >> {xfer_q.offset, 3'b000};

  // little endian, low bytes from the first beat, high bytes from the current one
  always_comb begin
    unique case (xfer_q.offset)
      2'b01:   word_rebuilt = {data_rdata_i[7:0], rdata_q[DATA_W-1:8]};
      2'b10:   word_rebuilt = {data_rdata_i[15:0], rdata_q[DATA_W-1:16]};
      2'b11:   word_rebuilt = {data_rdata_i[23:0], rdata_q[DATA_W-1:24]};
      default: word_rebuilt = data_rdata_i;
    endcase
  end

  // half word at offset 3 straddles two words
  assign half_raw = (xfer_q.offset == 2'b11) ? {data_rdata_i[7:0], rdata_q[DATA_W-1:24]} :
                                                beat_shift[15:0];

  // bytes never split
  assign byte_raw = beat_shift[7:0];

  ////////////////////
  // extension
  ////////////////////

  always_comb begin
    unique case (xfer_q.size)
      LSU_WORD: rdata_o = word_rebuilt;
      LSU_HALF: rdata_o = {{16{xfer_q.sign_ext & half_raw[15]}}, half_raw};
      // byte and the 2'b11 alias
      default:  rdata_o = {{24{xfer_q.sign_ext & byte_raw[7]}}, byte_raw};
    endcase
  end

  // attributes stay defined even when the FSM captures on a stray update
  a_xfer_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(xfer_q_o)
  );

endmodule

/* design/lsu_ctrl_fsm.sv */
// bus sequencing of one load or store, split into two beats when misaligned
// the execute stage holds the command until lsu_req_done_o
// a PMP-blocked request is never granted and gets no rvalid
// the registered PMP error then stands in for grant and response
module lsu_ctrl_fsm
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lsu_req_i,
  input  logic              we_i,
  input  lsu_type_e         size_i,
  input  logic [DATA_W-1:0] addr_i,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_bus_err_i,
  input  logic              data_pmp_err_i,
  input  xfer_ctrl_t        xfer_q_i,
  output logic              data_req_o,
  output logic              handle_mis_o,
  output logic              ctrl_update_o,
  output logic              rdata_update_o,
  output logic              addr_incr_req_o,
  output logic [DATA_W-1:0] addr_last_o,
  output logic              lsu_req_done_o,
  output logic              lsu_resp_valid_o,
  output logic              lsu_rdata_valid_o,
  output logic              load_err_o,
  output logic              store_err_o,
  output logic              busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

  ls_fsm_e           ls_fsm_cs, ls_fsm_ns;
  logic              split_access;
  logic              handle_mis_q, handle_mis_d;
  // address-phase PMP error of the current beat
  logic              pmp_err_q, pmp_err_d;
  // error seen on the first part of a split access
  logic              lsu_err_q, lsu_err_d;
  logic              addr_update;
  logic [DATA_W-1:0] addr_last_q, addr_last_d;
  logic              any_err;

  // word crossing a word boundary, or half word at offset 3
  assign split_access =
      ((size_i == LSU_WORD) && (addr_i[BYTE_OFFSET_W-1:0] != 2'b00)) ||
      ((size_i == LSU_HALF) && (addr_i[BYTE_OFFSET_W-1:0] == 2'b11));

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    ls_fsm_ns       = ls_fsm_cs;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    handle_mis_d    = handle_mis_q;
    pmp_err_d       = pmp_err_q;
    lsu_err_d       = lsu_err_q;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (ls_fsm_cs)
      IDLE: begin
        pmp_err_d = 1'b0;
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          pmp_err_d  = data_pmp_err_i;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            handle_mis_d  = split_access;
            ls_fsm_ns     = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      // first part of a split access still waiting for its grant
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i || pmp_err_q) begin
          addr_update   = 1'b1;
          ctrl_update_o = 1'b1;
          handle_mis_d  = 1'b1;
          ls_fsm_ns     = WAIT_RVALID_MIS;
        end
      end

      // second part on the bus, first response outstanding
      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i || pmp_err_q) begin
          // new address phase, its own PMP check
          pmp_err_d      = data_pmp_err_i;
          lsu_err_d      = data_bus_err_i | pmp_err_q;
          rdata_update_o = ~we_i;
          ls_fsm_ns      = data_gnt_i ? IDLE : WAIT_GNT;
          // keep the first failing address for the trap value
          addr_update    = data_gnt_i & ~(data_bus_err_i | pmp_err_q);
          handle_mis_d   = ~data_gnt_i;
        end else if (data_gnt_i) begin
          ls_fsm_ns    = WAIT_RVALID_MIS_GNTS_DONE;
          handle_mis_d = 1'b0;
        end
      end

      // unsplit access, or second part after the first response
      WAIT_GNT: begin
        addr_incr_req_o = handle_mis_q;
        data_req_o      = 1'b1;
        if (data_gnt_i || pmp_err_q) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~lsu_err_q;
          handle_mis_d  = 1'b0;
          ls_fsm_ns     = IDLE;
        end
      end

      // both parts granted, first response outstanding
      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          pmp_err_d      = data_pmp_err_i;
          // first part was granted, so no PMP error on it
          lsu_err_d      = data_bus_err_i;
          addr_update    = ~data_bus_err_i;
          rdata_update_o = ~we_i;
          ls_fsm_ns      = IDLE;
        end
      end

      default: ls_fsm_ns = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs    <= IDLE;
      handle_mis_q <= 1'b0;
      pmp_err_q    <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      ls_fsm_cs    <= ls_fsm_ns;
      handle_mis_q <= handle_mis_d;
      pmp_err_q    <= pmp_err_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  ////////////////////
  // last address
  ////////////////////

  // second part reports its word address
  assign addr_last_d = addr_incr_req_o ? {addr_i[DATA_W-1:BYTE_OFFSET_W], 2'b00} : addr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_last_d;
    end
  end

  ////////////////////
  // responses
  ////////////////////

  assign any_err           = lsu_err_q | data_bus_err_i | pmp_err_q;
  // final response always lands back in IDLE
  assign lsu_resp_valid_o  = (data_rvalid_i | pmp_err_q) & (ls_fsm_cs == IDLE);
  assign lsu_rdata_valid_o = (ls_fsm_cs == IDLE) & data_rvalid_i & ~any_err & ~xfer_q_i.we;
  assign load_err_o        = any_err & ~xfer_q_i.we & lsu_resp_valid_o;
  assign store_err_o       = any_err & xfer_q_i.we & lsu_resp_valid_o;
  assign lsu_req_done_o    = (lsu_req_i | (ls_fsm_cs != IDLE)) & (ls_fsm_ns == IDLE);
  assign handle_mis_o      = handle_mis_q;
  assign addr_last_o       = addr_last_q;
  assign busy_o            = (ls_fsm_cs != IDLE);

  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ls_fsm_cs inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID_MIS_GNTS_DONE}
  );

  // the execute stage must present a known address for every request
  a_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) data_req_o |-> !$isunknown(addr_i)
  );

  a_incr_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) addr_incr_req_o |-> busy_o
  );

endmodule

/* design/lsu_top.sv */
// load-store unit, one access in flight at a time on a req/gnt/rvalid bus
// addr_i must switch to the original address plus 4 while addr_incr_req_o is high
module lsu_top
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lsu_req_i,
  input  lsu_cmd_t          lsu_cmd_i,
  input  logic [DATA_W-1:0] addr_i,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_bus_err_i,
  input  logic              data_pmp_err_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  output logic              data_req_o,
  output data_bus_t         data_bus_o,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              lsu_rdata_valid_o,
  output logic              lsu_resp_valid_o,
  output logic              lsu_req_done_o,
  output logic              addr_incr_req_o,
  output logic [DATA_W-1:0] addr_last_o,
  output logic              load_err_o,
  output logic              store_err_o,
  output logic              busy_o
);

  logic              handle_mis;
  logic              ctrl_update;
  logic              rdata_update;
  xfer_ctrl_t        xfer_d;
  xfer_ctrl_t        xfer_q;
  logic [3:0]        be;
  logic [DATA_W-1:0] wdata_rot;

  // attributes of the beat being addressed
  always_comb begin
    xfer_d.offset   = addr_i[BYTE_OFFSET_W-1:0];
    xfer_d.size     = lsu_cmd_i.size;
    xfer_d.sign_ext = lsu_cmd_i.sign_ext;
    xfer_d.we       = lsu_cmd_i.we;
  end

  // bus address phase, always word aligned
  always_comb begin
    data_bus_o.addr  = {addr_i[DATA_W-1:BYTE_OFFSET_W], {BYTE_OFFSET_W{1'b0}}};
    data_bus_o.we    = lsu_cmd_i.we;
    data_bus_o.be    = be;
    data_bus_o.wdata = wdata_rot;
  end

  lsu_store_align u_store_align (
    .offset_i     (addr_i[BYTE_OFFSET_W-1:0]),
    .size_i       (lsu_cmd_i.size),
    .handle_mis_i (handle_mis),
    .wdata_i      (lsu_cmd_i.wdata),
    .be_o         (be),
    .wdata_o      (wdata_rot)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .xfer_i         (xfer_d),
    .data_rdata_i   (data_rdata_i),
    .xfer_q_o       (xfer_q),
    .rdata_o        (lsu_rdata_o)
  );

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .we_i              (lsu_cmd_i.we),
    .size_i            (lsu_cmd_i.size),
    .addr_i            (addr_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .data_pmp_err_i    (data_pmp_err_i),
    .xfer_q_i          (xfer_q),
    .data_req_o        (data_req_o),
    .handle_mis_o      (handle_mis),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .addr_incr_req_o   (addr_incr_req_o),
    .addr_last_o       (addr_last_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

endmodule

/* bench/lsu_checker.sv */
// watches the DUT ports and compares every response with a reference model
// the shadow memory follows granted bus writes that complete without error
// addresses must stay below 0x400, error windows are given as word ranges
module lsu_checker
  import lsu_pkg::*;
#(
  parameter logic [31:0] BERR_LO = 32'h200,
  parameter logic [31:0] BERR_HI = 32'h20c,
  parameter logic [31:0] PMP_LO  = 32'h300,
  parameter logic [31:0] PMP_HI  = 32'h30c
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  lsu_cmd_t    cmd_i,
  input  logic [31:0] addr_i,
  input  logic        busy_i,
  input  logic        req_done_i,
  input  logic        data_req_i,
  input  data_bus_t   data_bus_i,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic        data_bus_err_i,
  input  logic [31:0] rdata_i,
  input  logic        rdata_valid_i,
  input  logic        resp_valid_i,
  input  logic [31:0] addr_last_i,
  input  logic        load_err_i,
  input  logic        store_err_i,
  output int          err_cnt_o,
  output int          chk_cnt_o
);

  logic [7:0] shadow [1024];
  // granted beats waiting for their rvalid
  data_bus_t  beat_q [$];
  lsu_cmd_t   cmd_q;
  logic [31:0] addr_q;
  int         part;

  // same fill as the responder memory, a function of the word address
  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
    part      = 0;
    for (int i = 0; i < 256; i++) begin
      for (int k = 0; k < 4; k++) begin
        shadow[4*i+k] = 8'(((i + 1) * 32'h9e3779b1) >> (8 * k));
      end
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic in_win(input logic [31:0] a, input logic [31:0] lo,
                                  input logic [31:0] hi);
    return (a >= lo) && (a <= hi);
  endfunction

  function automatic logic is_split(input logic [31:0] a, input lsu_type_e size);
    return ((size == LSU_WORD) && (a[1:0] != 2'b00)) ||
           ((size == LSU_HALF) && (a[1:0] == 2'b11));
  endfunction

  function automatic logic word_err(input logic [31:0] w);
    return in_win(w, BERR_LO, BERR_HI) || in_win(w, PMP_LO, PMP_HI);
  endfunction

  // any failing part fails the whole access
  function automatic logic ref_err(input logic [31:0] a, input lsu_type_e size);
    logic [31:0] w0;
    w0 = {a[31:2], 2'b00};
    return word_err(w0) || (is_split(a, size) && word_err(w0 + 32'd4));
  endfunction

  // little-endian gather from the shadow, then extension
  function automatic logic [31:0] ref_load(input logic [31:0] a, input lsu_type_e size,
                                           input logic sign);
    logic [31:0] v;
    int          n;
    n = (size == LSU_WORD) ? 4 : (size == LSU_HALF) ? 2 : 1;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[8*k +: 8] = shadow[a[9:0] + k];
    end
    if (sign && (n == 2)) v = {{16{v[15]}}, v[15:0]};
    if (sign && (n == 1)) v = {{24{v[7]}}, v[7:0]};
    return v;
  endfunction

  // lane k of part p is enabled when its byte lies inside the access
  function automatic logic [3:0] ref_be(input logic [1:0] off, input lsu_type_e size,
                                        input int p);
    logic [3:0] be;
    int         n;
    int         pos;
    n = (size == LSU_WORD) ? 4 : (size == LSU_HALF) ? 2 : 1;
    for (int k = 0; k < 4; k++) begin
      pos   = 4 * p + k - int'(off);
      be[k] = (pos >= 0) && (pos < n);
    end
    return be;
  endfunction

  // store data on the bus, byte b of the command sits on lane b + offset
  function automatic logic [31:0] ref_lanes(input logic [31:0] wd, input logic [1:0] off);
    logic [31:0] v;
    logic [1:0]  lane;
    v = '0;
    for (int b = 0; b < 4; b++) begin
      lane           = 2'(b) + off;
      v[8*lane +: 8] = wd[8*b +: 8];
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt_o++;
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h (access at 0x%h)", name, got, exp, addr_q);
      err_cnt_o++;
    end
  endtask

  ////////////////////
  // compare process
  ////////////////////

  always @(posedge clk_i) begin : compare
    data_bus_t   b;
    logic        e;
    logic [31:0] last;
    if (rst_ni) begin
      // first cycle of a new command
      if (req_i && !busy_i) begin
        cmd_q  = cmd_i;
        addr_q = addr_i;
        part   = 0;
        // only an unsplit access granted at once completes in its request cycle
        check("lsu_req_done_o", req_done_i, !is_split(addr_i, cmd_i.size) && data_gnt_i);
      end
      // responses retire the oldest beat first
      if (data_rvalid_i && (beat_q.size() > 0)) begin
        b = beat_q.pop_front();
        if (b.we && !data_bus_err_i) begin
          for (int k = 0; k < 4; k++) begin
            if (b.be[k]) shadow[b.addr[9:0] + k] = b.wdata[8*k +: 8];
          end
        end
      end
      if (resp_valid_i) begin
        e    = ref_err(addr_q, cmd_q.size);
        // second part reports its word address unless the first part failed
        last = (is_split(addr_q, cmd_q.size) && !word_err({addr_q[31:2], 2'b00})) ?
               {addr_q[31:2], 2'b00} + 32'd4 : addr_q;
        check("addr_last_o", addr_last_i, last);
        check("load_err_o", load_err_i, e && !cmd_q.we);
        check("store_err_o", store_err_i, e && cmd_q.we);
        check("lsu_rdata_valid_o", rdata_valid_i, !e && !cmd_q.we);
        if (!e) check("bus beat count", part, is_split(addr_q, cmd_q.size) ? 2 : 1);
        if (!e && !cmd_q.we) begin
          check("lsu_rdata_o", rdata_i, ref_load(addr_q, cmd_q.size, cmd_q.sign_ext));
        end
      end
      if (data_req_i && data_gnt_i) begin
        if (!ref_err(addr_q, cmd_q.size)) begin
          check("data_bus_o.addr", data_bus_i.addr, {addr_q[31:2], 2'b00} + 32'(4 * part));
          check("data_bus_o.be", data_bus_i.be, ref_be(addr_q[1:0], cmd_q.size, part));
        end
        check("data_bus_o.we", data_bus_i.we, cmd_q.we);
        if (cmd_q.we) begin
          check("data_bus_o.wdata", data_bus_i.wdata, ref_lanes(cmd_q.wdata, addr_q[1:0]));
        end
        beat_q.push_back(data_bus_i);
        part++;
      end
    end
  end

endmodule

/* bench/lsu_tb.sv */
// testbench of the load-store unit with a req/gnt/rvalid memory responder
// responder memory is 256 words, all test addresses stay below 0x400
module lsu_tb
  import lsu_pkg::*;
();

  localparam int          TIMEOUT = 100;
  localparam logic [31:0] BERR_LO = 32'h200;
  localparam logic [31:0] BERR_HI = 32'h20c;
  localparam logic [31:0] PMP_LO  = 32'h300;
  localparam logic [31:0] PMP_HI  = 32'h30c;

  // one granted beat waiting for its response
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] due;
  } beat_t;

  logic        clk_i, rst_ni, lsu_req_i, data_gnt_i, data_rvalid_i;
  logic        data_bus_err_i, data_pmp_err_i, data_req_o, lsu_rdata_valid_o;
  logic        lsu_resp_valid_o, lsu_req_done_o, addr_incr_req_o;
  logic        load_err_o, store_err_o, busy_o;
  lsu_cmd_t    lsu_cmd_i;
  data_bus_t   data_bus_o;
  logic [31:0] addr_i, data_rdata_i, lsu_rdata_o, addr_last_o;
  logic [31:0] mem [256];
  logic [31:0] rng_q;
  beat_t       pend_q [$];
  int          cyc, gnt_wait, err_cnt, chk_cnt, err_mark, timeouts;
  logic        gnt_q;

  always #20 clk_i = ~clk_i;

  lsu_top i_dut (.*);

  lsu_checker #(
    .BERR_LO (BERR_LO), .BERR_HI (BERR_HI), .PMP_LO (PMP_LO), .PMP_HI (PMP_HI)
  ) u_checker (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (lsu_req_i), .cmd_i (lsu_cmd_i),
    .addr_i (addr_i), .busy_i (busy_o), .req_done_i (lsu_req_done_o),
    .data_req_i (data_req_o),
    .data_bus_i (data_bus_o), .data_gnt_i (data_gnt_i), .data_rvalid_i (data_rvalid_i),
    .data_bus_err_i (data_bus_err_i), .rdata_i (lsu_rdata_o),
    .rdata_valid_i (lsu_rdata_valid_o), .resp_valid_i (lsu_resp_valid_o),
    .addr_last_i (addr_last_o), .load_err_i (load_err_o), .store_err_i (store_err_o),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  function automatic logic in_win(input logic [31:0] a, input logic [31:0] lo,
                                  input logic [31:0] hi);
    return (a >= lo) && (a <= hi);
  endfunction

  ////////////////////
  // bus responder
  ////////////////////

  // PMP blocks in the address phase, such a request never sees a grant
  assign data_pmp_err_i = data_req_o && in_win(data_bus_o.addr, PMP_LO, PMP_HI);
  assign data_gnt_i     = gnt_q & ~data_pmp_err_i;

  always @(posedge clk_i) begin : grant_track
    beat_t b;
    cyc++;
    if (rst_ni && data_req_o && data_gnt_i) begin
      b.addr  = data_bus_o.addr;
      b.we    = data_bus_o.we;
      b.be    = data_bus_o.be;
      b.wdata = data_bus_o.wdata;
      // response 1 to 3 cycles after the grant
      b.due   = cyc + (next_rand() % 3);
      pend_q.push_back(b);
      gnt_wait = next_rand() % 4;
    end else if (data_req_o && (gnt_wait > 0)) begin
      gnt_wait--;
    end
  end

  always @(negedge clk_i) begin : respond
    beat_t b;
    gnt_q          = (gnt_wait == 0);
    data_rvalid_i  = 1'b0;
    data_bus_err_i = 1'b0;
    if ((pend_q.size() > 0) && (pend_q[0].due <= cyc)) begin
      b              = pend_q.pop_front();
      data_rvalid_i  = 1'b1;
      data_bus_err_i = in_win(b.addr, BERR_LO, BERR_HI);
      data_rdata_i   = mem[b.addr[9:2]];
      // a failing store leaves memory alone
      if (b.we && !data_bus_err_i) begin
        for (int k = 0; k < 4; k++) begin
          if (b.be[k]) mem[b.addr[9:2]][8*k +: 8] = b.wdata[8*k +: 8];
        end
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic end_run();
    $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timeouts);
    if ((err_cnt == 0) && (timeouts == 0) && (chk_cnt > 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // one command, held until done, then wait for its response
  task automatic access(input logic we, input lsu_type_e size, input logic sign,
                        input logic [31:0] addr, input logic [31:0] wdata);
    int   n;
    logic done;
    @(negedge clk_i);
    lsu_req_i          = 1'b1;
    lsu_cmd_i.we       = we;
    lsu_cmd_i.size     = size;
    lsu_cmd_i.sign_ext = sign;
    lsu_cmd_i.wdata    = wdata;
    addr_i             = addr;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = lsu_req_done_o;
      @(negedge clk_i);
      n++;
      if (done) begin
        lsu_req_i = 1'b0;
      end else if (n > TIMEOUT) begin
        $display("timeout: request at 0x%h was never accepted", addr);
        timeouts++;
        end_run();
      end else begin
        // second part of a split access uses the next word
        addr_i = addr_incr_req_o ? addr + 32'd4 : addr;
      end
    end
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = lsu_resp_valid_o;
      n++;
      if (!done && (n > TIMEOUT)) begin
        $display("timeout: no response for the access at 0x%h", addr);
        timeouts++;
        end_run();
      end
    end
  endtask

  task automatic report_test(input string name);
    if (err_cnt == err_mark) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_cmd_i      = '0;
    addr_i         = '0;
    data_rvalid_i  = 1'b0;
    data_bus_err_i = 1'b0;
    data_rdata_i   = '0;
    gnt_q          = 1'b0;
    rng_q          = 32'h93a1;
    cyc            = 0;
    gnt_wait       = 0;
    err_mark       = 0;
    timeouts       = 0;
    for (int i = 0; i < 256; i++) mem[i] = (i + 1) * 32'h9e3779b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    access(1'b1, LSU_WORD, 1'b0, 32'h40, 32'hcafe_f00d);
    access(1'b0, LSU_WORD, 1'b0, 32'h40, '0);
    report_test("aligned word");

    for (int off = 0; off < 4; off++) begin
      access(1'b0, LSU_BYTE, 1'b0, 32'h50 + off, '0);
      access(1'b0, LSU_BYTE, 1'b1, 32'h50 + off, '0);
      access(1'b1, LSU_BYTE, 1'b0, 32'h44 + off, 32'h80 + off);
      if (off < 3) access(1'b0, LSU_HALF, 1'b1, 32'h60 + off, '0);
      if (off < 3) access(1'b0, LSU_HALF, 1'b0, 32'h60 + off, '0);
    end
    access(1'b0, LSU_WORD, 1'b0, 32'h44, '0);
    report_test("byte and half");

    for (int off = 1; off < 4; off++) begin
      access(1'b1, LSU_WORD, 1'b0, 32'h80 + 8 * off + off, 32'h1234_5678 * off);
      access(1'b0, LSU_WORD, 1'b0, 32'h80 + 8 * off + off, '0);
    end
    access(1'b1, LSU_HALF, 1'b0, 32'h93, 32'h0000_9abc);
    access(1'b0, LSU_HALF, 1'b1, 32'h93, '0);
    report_test("misaligned split");

    access(1'b0, LSU_WORD, 1'b0, 32'h204, '0);
    access(1'b1, LSU_BYTE, 1'b0, 32'h206, 32'h55);
    access(1'b0, LSU_WORD, 1'b0, 32'h1fe, '0);
    access(1'b1, LSU_WORD, 1'b0, 32'h20e, 32'h0bad_cafe);
    report_test("bus error");

    access(1'b0, LSU_WORD, 1'b0, 32'h304, '0);
    access(1'b1, LSU_WORD, 1'b0, 32'h308, 32'h1111_2222);
    access(1'b0, LSU_WORD, 1'b0, 32'h2fd, '0);
    access(1'b1, LSU_WORD, 1'b0, 32'h30f, 32'h3333_4444);
    access(1'b0, LSU_WORD, 1'b0, 32'h40, '0);
    report_test("pmp error");

    // random traffic stays clear of both error windows
    for (int i = 0; i < 200; i++) begin
      access(next_rand() % 2, lsu_type_e'(next_rand() % 4), next_rand() % 2,
             next_rand() % 256, next_rand());
    end
    report_test("random mix");
    end_run();
  end

endmodule

/* verilog.f */
design/lsu_pkg.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_ctrl_fsm.sv
design/lsu_top.sv
bench/lsu_checker.sv
bench/lsu_tb.sv
